// File: src/pkg_csr_engine.sv
// Types and widths shared by the CSR index engine RTL and its testbench
// ADDR_W and DATA_W are expected to be equal; FIFO sizing is set on the top level
`default_nettype none

package pkg_csr_engine;

    // --------------------------------------------------
    // Widths
    // --------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEQ_W  = 16;

    // Bytes per CSR index entry, one index step
    localparam int ELEM_BYTES = 4;

    // Fields that make up one configuration record
    localparam int NUM_CFG_FIELDS = 4;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    // All-zero packet is neither command
    typedef enum logic [1:0] {
        CMD_CONFIGURE = 2'd1,
        CMD_MEM_READ  = 2'd2
    } mem_cmd_e;

    typedef enum logic [1:0] {
        CFG_INDEX_START = 2'd0,
        CFG_INDEX_END   = 2'd1,
        CFG_STRIDE      = 2'd2,
        CFG_ARRAY_BASE  = 2'd3
    } cfg_field_e;

    typedef enum logic [2:0] {
        GEN_IDLE     = 3'd0,
        GEN_WAIT_CFG = 3'd1,
        GEN_BUSY     = 3'd2,
        GEN_PAUSE    = 3'd3,
        GEN_DONE     = 3'd4
    } gen_state_e;

    // --------------------------------------------------
    // Records
    // --------------------------------------------------
    // Config response: field selects, data carries the value
    // Read request: address is the byte address, seq the tag
    typedef struct packed {
        logic              valid;
        mem_cmd_e          cmd;
        cfg_field_e        field;
        logic [ADDR_W-1:0] address;
        logic [DATA_W-1:0] data;
        logic [SEQ_W-1:0]  seq;
    } mem_packet_t;

    // One complete walk setup
    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] index_start;
        logic [DATA_W-1:0] index_end;
        logic [DATA_W-1:0] stride;
        logic [ADDR_W-1:0] array_base;
    } csr_config_t;

    // Kernel descriptor, valid starts a run
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] graph_base;
    } descriptor_t;

endpackage

`default_nettype wire

// File: src/csr_config_decode.sv
// Collects CMD_CONFIGURE responses into one record, other commands are dropped
// All four fields must arrive again after each consume before cfg_o.valid rises
`timescale 1ns/100ps
`default_nettype none

module csr_config_decode (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  pkg_csr_engine::mem_packet_t response_i,
    input  logic                        cfg_consume_i,
    output pkg_csr_engine::csr_config_t cfg_o
);

    localparam int AW = pkg_csr_engine::ADDR_W;
    localparam int NF = pkg_csr_engine::NUM_CFG_FIELDS;

    logic [NF-1:0]               seen_q;
    logic [NF-1:0]               seen_next;
    logic                        cfg_write;
    pkg_csr_engine::csr_config_t cfg_q;

    assign cfg_write = response_i.valid && (response_i.cmd == pkg_csr_engine::CMD_CONFIGURE);

    // --------------------------------------------------
    // Field tracking
    // --------------------------------------------------
    // Consume clears the flags, a field arriving in the same cycle still counts
    always_comb begin
        seen_next = cfg_consume_i ? '0 : seen_q;
        if (cfg_write) begin
            seen_next[response_i.field] = 1'b1;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            seen_q      <= '0;
            cfg_q.valid <= 1'b0;
        end else begin
            seen_q      <= seen_next;
            // One cycle after the last distinct field lands
            cfg_q.valid <= (&seen_q) && !cfg_consume_i;
        end
    end

    // --------------------------------------------------
    // Field storage
    // --------------------------------------------------
    // Later write to the same field wins
    always_ff @(posedge ap_clk) begin
        if (cfg_write) begin
            case (response_i.field)
                pkg_csr_engine::CFG_INDEX_START: begin
                    cfg_q.index_start <= response_i.data;
                end
                pkg_csr_engine::CFG_INDEX_END: begin
                    cfg_q.index_end <= response_i.data;
                end
                pkg_csr_engine::CFG_STRIDE: begin
                    cfg_q.stride <= response_i.data;
                end
                pkg_csr_engine::CFG_ARRAY_BASE: begin
                    cfg_q.array_base <= AW'(response_i.data);
                end
                default: begin
                end
            endcase
        end
    end

    assign cfg_o = cfg_q;

    // Generator may only take a record that has been completed
    a_consume_needs_cfg: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        cfg_consume_i |-> cfg_o.valid
    ) else $error("cfg_consume_i while configuration incomplete");

endmodule

`default_nettype wire

// File: src/csr_index_generator.sv
// Walks index_start up to index_end by stride, one read request per index
// Stride must be nonzero and index_end plus stride must not wrap the index width
`timescale 1ns/100ps
`default_nettype none

module csr_index_generator #(
    parameter int PROG_THRESH = 16
) (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  pkg_csr_engine::descriptor_t descriptor_i,
    input  pkg_csr_engine::csr_config_t cfg_i,
    input  logic                        fifo_prog_full_i,
    input  logic                        fifo_empty_i,
    output logic                        cfg_consume_o,
    output pkg_csr_engine::mem_packet_t request_o,
    output logic                        done_o
);

    localparam int AW = pkg_csr_engine::ADDR_W;
    localparam int BW = 16;

    pkg_csr_engine::gen_state_e        state_q;
    pkg_csr_engine::csr_config_t       cfg_q;
    logic [AW-1:0]                     graph_base_q;
    logic [pkg_csr_engine::DATA_W-1:0] index_q;
    logic [pkg_csr_engine::SEQ_W-1:0]  seq_q;
    logic                              accept_desc;
    logic                              start_run;
    logic                              in_range;
    logic                              push;
    logic [AW-1:0]                     req_addr;
    logic [BW-1:0]                     burst_q;

    assign accept_desc = descriptor_i.valid &&
                         (state_q == pkg_csr_engine::GEN_IDLE ||
                          state_q == pkg_csr_engine::GEN_DONE);
    assign start_run   = (state_q == pkg_csr_engine::GEN_WAIT_CFG) && cfg_i.valid;
    assign in_range    = index_q < cfg_q.index_end;
    assign push        = (state_q == pkg_csr_engine::GEN_BUSY) && in_range && !fifo_prog_full_i;

    // graph_base + array_base + index * entry size
    assign req_addr = graph_base_q + cfg_q.array_base +
                      AW'(index_q) * AW'(pkg_csr_engine::ELEM_BYTES);

    // --------------------------------------------------
    // Run FSM
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            state_q         <= pkg_csr_engine::GEN_IDLE;
            cfg_consume_o   <= 1'b0;
            request_o.valid <= 1'b0;
        end else begin
            cfg_consume_o   <= start_run;
            request_o.valid <= push;
            case (state_q)
                pkg_csr_engine::GEN_IDLE, pkg_csr_engine::GEN_DONE: begin
                    if (accept_desc) begin
                        state_q <= pkg_csr_engine::GEN_WAIT_CFG;
                    end
                end
                pkg_csr_engine::GEN_WAIT_CFG: begin
                    if (start_run) begin
                        state_q <= pkg_csr_engine::GEN_BUSY;
                    end
                end
                pkg_csr_engine::GEN_BUSY: begin
                    if (!in_range) begin
                        state_q <= pkg_csr_engine::GEN_DONE;
                    end else if (fifo_prog_full_i) begin
                        state_q <= pkg_csr_engine::GEN_PAUSE;
                    end
                end
                pkg_csr_engine::GEN_PAUSE: begin
                    if (!fifo_prog_full_i) begin
                        state_q <= pkg_csr_engine::GEN_BUSY;
                    end
                end
                default: begin
                    state_q <= pkg_csr_engine::GEN_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Walk registers and request payload
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (accept_desc) begin
            graph_base_q <= descriptor_i.graph_base;
        end
        if (start_run) begin
            cfg_q   <= cfg_i;
            index_q <= cfg_i.index_start;
            seq_q   <= '0;
        end else if (push) begin
            index_q <= index_q + cfg_q.stride;
            seq_q   <= seq_q + 1'b1;
        end
        if (push) begin
            request_o.cmd     <= pkg_csr_engine::CMD_MEM_READ;
            request_o.field   <= pkg_csr_engine::CFG_INDEX_START;
            request_o.address <= req_addr;
            request_o.data    <= index_q;
            request_o.seq     <= seq_q;
        end
    end

    // Level, drops when the next descriptor is taken
    assign done_o = (state_q == pkg_csr_engine::GEN_DONE) && fifo_empty_i;

    // Writes landed in the FIFO since it was last seen empty, saturating
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            burst_q <= '0;
        end else if (fifo_empty_i) begin
            burst_q <= BW'(request_o.valid);
        end else if (request_o.valid && !(&burst_q)) begin
            burst_q <= burst_q + 1'b1;
        end
    end

    // Only the push already in flight may land after prog_full rises
    a_no_push_prog_full: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        $past(fifo_prog_full_i) |-> !request_o.valid
    ) else $error("push launched while FIFO prog_full");

    // FIFO cannot report prog_full before PROG_THRESH writes since empty
    a_prog_full_count: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        fifo_prog_full_i |-> (burst_q >= BW'(PROG_THRESH))
    ) else $error("prog_full seen after too few pushes");

endmodule

`default_nettype wire

// File: src/csr_request_fifo.sv
// Request queue, ready right after reset; pop data is valid one cycle after rd_en_i
// PROG_THRESH must stay below FIFO_DEPTH to leave room for the push in flight
`timescale 1ns/100ps
`default_nettype none

module csr_request_fifo #(
    parameter int FIFO_DEPTH  = 32,
    parameter int PROG_THRESH = 16
) (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  pkg_csr_engine::mem_packet_t push_i,
    input  logic                        rd_en_i,
    output pkg_csr_engine::mem_packet_t pop_o,
    output logic                        prog_full_o,
    output logic                        empty_o
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    pkg_csr_engine::mem_packet_t mem_q [FIFO_DEPTH];
    pkg_csr_engine::mem_packet_t pop_data_q;
    logic                        pop_valid_q;
    logic [PW-1:0]               wr_ptr_q;
    logic [PW-1:0]               rd_ptr_q;
    logic [CW-1:0]               count_q;
    logic                        full;
    logic                        wr_en;
    logic                        rd_en;

    // Wraps at any depth, not only powers of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        if (ptr == PW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full        = (count_q == CW'(FIFO_DEPTH));
    assign empty_o     = (count_q == '0);
    assign prog_full_o = (count_q >= CW'(PROG_THRESH));
    assign wr_en       = push_i.valid && !full;
    assign rd_en       = rd_en_i && !empty_o;

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            wr_ptr_q    <= '0;
            rd_ptr_q    <= '0;
            count_q     <= '0;
            pop_valid_q <= 1'b0;
        end else begin
            pop_valid_q <= rd_en;
            if (wr_en) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (rd_en) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({wr_en, rd_en})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= push_i;
        end
        if (rd_en) begin
            pop_data_q <= mem_q[rd_ptr_q];
        end
    end

    always_comb begin
        pop_o       = pop_data_q;
        pop_o.valid = pop_valid_q;
    end

    // Generator back-pressure must keep the queue from overflowing
    a_no_overflow: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        push_i.valid |-> !full
    ) else $error("push into full request FIFO");

    a_empty_read: assert property (
        @(posedge ap_clk) disable iff (areset_csr_engine)
        (rd_en_i && empty_o) |=> !pop_o.valid
    ) else $error("read of empty FIFO produced valid data");

endmodule

`default_nettype wire

// File: src/engine_csr_index.sv
// CSR index engine top; inputs and outputs are registered once
// rd_en to request_o.valid is 3 cycles, done_o is a level until the next descriptor
`timescale 1ns/100ps
`default_nettype none

module engine_csr_index #(
    parameter int FIFO_DEPTH  = 32,
    parameter int PROG_THRESH = 16
) (
    input  logic                        ap_clk,
    input  logic                        areset_csr_engine,
    input  pkg_csr_engine::descriptor_t descriptor_i,
    input  pkg_csr_engine::mem_packet_t response_memory_i,
    input  logic                        request_rd_en_i,
    output pkg_csr_engine::mem_packet_t request_o,
    output logic                        done_o
);

    pkg_csr_engine::descriptor_t descriptor_q;
    pkg_csr_engine::mem_packet_t response_q;
    logic                        rd_en_q;
    pkg_csr_engine::csr_config_t cfg;
    logic                        cfg_consume;
    pkg_csr_engine::mem_packet_t push_req;
    pkg_csr_engine::mem_packet_t pop_req;
    logic                        fifo_prog_full;
    logic                        fifo_empty;
    logic                        gen_done;

    // --------------------------------------------------
    // Input registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            descriptor_q.valid <= 1'b0;
            response_q.valid   <= 1'b0;
            rd_en_q            <= 1'b0;
        end else begin
            descriptor_q.valid <= descriptor_i.valid;
            response_q.valid   <= response_memory_i.valid;
            rd_en_q            <= request_rd_en_i;
        end
    end

    always_ff @(posedge ap_clk) begin
        descriptor_q.graph_base <= descriptor_i.graph_base;
        response_q.cmd          <= response_memory_i.cmd;
        response_q.field        <= response_memory_i.field;
        response_q.address      <= response_memory_i.address;
        response_q.data         <= response_memory_i.data;
        response_q.seq          <= response_memory_i.seq;
    end

    // --------------------------------------------------
    // Output registers
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_engine) begin
            request_o.valid <= 1'b0;
            done_o          <= 1'b0;
        end else begin
            request_o.valid <= pop_req.valid;
            done_o          <= gen_done;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_o.cmd     <= pop_req.cmd;
        request_o.field   <= pop_req.field;
        request_o.address <= pop_req.address;
        request_o.data    <= pop_req.data;
        request_o.seq     <= pop_req.seq;
    end

    // Decode, execute, result
    csr_config_decode u_decode (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .response_i       (response_q),
        .cfg_consume_i    (cfg_consume),
        .cfg_o            (cfg)
    );

    csr_index_generator #(
        .PROG_THRESH(PROG_THRESH)
    ) u_generator (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .descriptor_i     (descriptor_q),
        .cfg_i            (cfg),
        .fifo_prog_full_i (fifo_prog_full),
        .fifo_empty_i     (fifo_empty),
        .cfg_consume_o    (cfg_consume),
        .request_o        (push_req),
        .done_o           (gen_done)
    );

    csr_request_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .push_i           (push_req),
        .rd_en_i          (rd_en_q),
        .pop_o            (pop_req),
        .prog_full_o      (fifo_prog_full),
        .empty_o          (fifo_empty)
    );

endmodule

`default_nettype wire

// File: verification/tb_engine_csr_index.sv
// Self-checking testbench for the CSR index engine, stops at the first mismatch
// Runs keep index_end plus stride small so the 32-bit index never wraps
`timescale 1ns/100ps
`default_nettype none

module tb_engine_csr_index;

    localparam int FIFO_DEPTH  = 32;
    localparam int PROG_THRESH = 16;

    logic                        ap_clk;
    logic                        areset_csr_engine;
    pkg_csr_engine::descriptor_t descriptor_i;
    pkg_csr_engine::mem_packet_t response_memory_i;
    logic                        request_rd_en_i;
    pkg_csr_engine::mem_packet_t request_o;
    logic                        done_o;

    pkg_csr_engine::mem_packet_t exp_q[$];
    logic                        armed = 1'b0;
    int                          rd_mode = 0;
    logic [15:0]                 lfsr_cfg = 16'd75;
    logic [15:0]                 lfsr_rd = 16'd75;

    engine_csr_index #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .PROG_THRESH(PROG_THRESH)
    ) dut0 (
        .ap_clk           (ap_clk),
        .areset_csr_engine(areset_csr_engine),
        .descriptor_i     (descriptor_i),
        .response_memory_i(response_memory_i),
        .request_rd_en_i  (request_rd_en_i),
        .request_o        (request_o),
        .done_o           (done_o)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_cfg = lfsr_next(lfsr_cfg);
            v = {v[30:0], lfsr_cfg[0]};
        end
    endtask

    // Expected request stream of one run, appended to exp_q
    function automatic int reference_requests(input logic [31:0] start, input logic [31:0] stop,
                                              input logic [31:0] stride,
                                              input logic [31:0] array_base,
                                              input logic [31:0] graph_base);
        logic [31:0]                 idx;
        logic [15:0]                 seq;
        pkg_csr_engine::mem_packet_t pkt;
        int                          n;
        idx = start;
        seq = '0;
        n = 0;
        while (idx < stop) begin
            pkt = '0;
            pkt.valid = 1'b1;
            pkt.cmd = pkg_csr_engine::CMD_MEM_READ;
            pkt.address = graph_base + array_base + idx * pkg_csr_engine::ELEM_BYTES;
            pkt.seq = seq;
            exp_q.push_back(pkt);
            idx = idx + stride;
            seq = seq + 1'b1;
            n++;
        end
        return n;
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_request(input pkg_csr_engine::mem_packet_t exp,
                                 input pkg_csr_engine::mem_packet_t act);
        if (act.cmd !== exp.cmd) begin
            $display("Error: time %0t, request_o.cmd expected %0d actual %0d",
                     $time, exp.cmd, act.cmd);
            abort_run();
        end
        if (act.address !== exp.address) begin
            $display("Error: time %0t, request_o.address expected %h actual %h",
                     $time, exp.address, act.address);
            abort_run();
        end
        if (act.seq !== exp.seq) begin
            $display("Error: time %0t, request_o.seq expected %0d actual %0d",
                     $time, exp.seq, act.seq);
            abort_run();
        end
    endtask

    task automatic check_done(input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error: time %0t, done_o expected %b actual %b", $time, exp, act);
            abort_run();
        end
    endtask

    task automatic wait_level(input logic level, input int max_cycles);
        int   cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < max_cycles) begin
            @(negedge ap_clk);
            seen = (done_o === level);
            cycles++;
        end
        if (!seen) begin
            $display("Timeout: done_o did not reach %b within %0d cycles", level, max_cycles);
            abort_run();
        end
    endtask

    task automatic set_rd_mode(input int m);
        @(negedge ap_clk);
        rd_mode = m;
    endtask

    task automatic set_armed(input logic a);
        @(posedge ap_clk);
        #1;
        armed = a;
    endtask

    task automatic drive_response(input pkg_csr_engine::mem_cmd_e cmd,
                                  input pkg_csr_engine::cfg_field_e field,
                                  input logic [31:0] value);
        @(posedge ap_clk);
        #1;
        response_memory_i.valid = 1'b1;
        response_memory_i.cmd = cmd;
        response_memory_i.field = field;
        response_memory_i.address = '0;
        response_memory_i.data = value;
        response_memory_i.seq = '0;
        @(posedge ap_clk);
        #1;
        response_memory_i.valid = 1'b0;
    endtask

    task automatic send_descriptor(input logic [31:0] graph_base);
        @(posedge ap_clk);
        #1;
        descriptor_i.valid = 1'b1;
        descriptor_i.graph_base = graph_base;
        @(posedge ap_clk);
        #1;
        descriptor_i.valid = 1'b0;
    endtask

    // Config first, then descriptor; optional pop stall before draining
    task automatic run_walk(input logic [31:0] start, input logic [31:0] stop,
                            input logic [31:0] stride, input logic [31:0] abase,
                            input logic [31:0] gbase, input int hold_cycles,
                            input int max_cycles);
        int n;
        drive_response(pkg_csr_engine::CMD_CONFIGURE, pkg_csr_engine::CFG_INDEX_START, start);
        drive_response(pkg_csr_engine::CMD_CONFIGURE, pkg_csr_engine::CFG_INDEX_END, stop);
        drive_response(pkg_csr_engine::CMD_CONFIGURE, pkg_csr_engine::CFG_STRIDE, stride);
        drive_response(pkg_csr_engine::CMD_CONFIGURE, pkg_csr_engine::CFG_ARRAY_BASE, abase);
        n = reference_requests(start, stop, stride, abase, gbase);
        $display("Run at %0t: %0d requests expected", $time, n);
        send_descriptor(gbase);
        wait_level(1'b0, 20);
        set_armed(1'b1);
        if (hold_cycles > 0) begin
            repeat (hold_cycles) @(posedge ap_clk);
            set_rd_mode(1);
        end
        wait_level(1'b1, max_cycles);
        set_armed(1'b0);
    endtask

    // --------------------------------------------------
    // Pop strobe driver and response monitor
    // --------------------------------------------------
    initial begin
        request_rd_en_i = 1'b0;
        forever begin
            @(posedge ap_clk);
            #1;
            case (rd_mode)
                0: request_rd_en_i = 1'b0;
                1: request_rd_en_i = 1'b1;
                default: begin
                    lfsr_rd = lfsr_next(lfsr_rd);
                    request_rd_en_i = lfsr_rd[0];
                end
            endcase
        end
    end

    always @(negedge ap_clk) begin : monitor
        pkg_csr_engine::mem_packet_t exp_pkt;
        if (!areset_csr_engine) begin
            if (request_o.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected request_o pulse at %0t with nothing expected", $time);
                    abort_run();
                end
                exp_pkt = exp_q.pop_front();
                check_request(exp_pkt, request_o);
            end
            // Done may not rise while requests are still owed
            if (armed && done_o === 1'b1 && exp_q.size() != 0) begin
                check_done(1'b0, done_o);
            end
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    initial begin
        logic [31:0] v_start;
        logic [31:0] v_span;
        logic [31:0] v_stride;
        logic [31:0] v_abase;
        logic [31:0] v_gbase;
        areset_csr_engine = 1'b1;
        descriptor_i = '0;
        response_memory_i = '0;
        repeat (3) @(posedge ap_clk);
        #1;
        areset_csr_engine = 1'b0;

        // Idle after reset
        repeat (20) begin
            @(negedge ap_clk);
            check_done(1'b0, done_o);
        end

        // Basic run
        set_rd_mode(1);
        run_walk(32'd2, 32'd20, 32'd3, 32'h1000, 32'h0010_0000, 0, 500);

        // Long run with pops stalled
        set_rd_mode(0);
        run_walk(32'd0, 32'd200, 32'd2, 32'h4000, 32'h0200_0000, 60, 2000);

        // Descriptor first, shuffled fields, repeated end, stray read packet
        send_descriptor(32'h0030_0000);
        wait_level(1'b0, 20);
        set_armed(1'b1);
        drive_response(pkg_csr_engine::CMD_CONFIGURE, pkg_csr_engine::CFG_STRIDE, 32'd3);
        drive_response(pkg_csr_engine::CMD_CONFIGURE, pkg_csr_engine::CFG_INDEX_END, 32'd999);
        drive_response(pkg_csr_engine::CMD_CONFIGURE, pkg_csr_engine::CFG_ARRAY_BASE, 32'h200);
        drive_response(pkg_csr_engine::CMD_CONFIGURE, pkg_csr_engine::CFG_INDEX_END, 32'd40);
        drive_response(pkg_csr_engine::CMD_MEM_READ, pkg_csr_engine::CFG_INDEX_START, 32'd5);
        repeat (20) begin
            @(negedge ap_clk);
            check_done(1'b0, done_o);
        end
        void'(reference_requests(32'd7, 32'd40, 32'd3, 32'h200, 32'h0030_0000));
        drive_response(pkg_csr_engine::CMD_CONFIGURE, pkg_csr_engine::CFG_INDEX_START, 32'd7);
        wait_level(1'b1, 500);
        set_armed(1'b0);

        // Random runs with random pops
        set_rd_mode(2);
        for (int r = 0; r < 5; r++) begin
            draw_bits(8, v_start);
            draw_bits(7, v_span);
            draw_bits(2, v_stride);
            draw_bits(20, v_abase);
            draw_bits(24, v_gbase);
            run_walk(v_start, v_start + v_span + 1, v_stride + 1, v_abase, v_gbase, 0, 3000);
        end

        set_rd_mode(1);
        repeat (10) @(posedge ap_clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected requests never arrived", exp_q.size());
            abort_run();
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
src/pkg_csr_engine.sv
src/csr_config_decode.sv
src/csr_index_generator.sv
src/csr_request_fifo.sv
src/engine_csr_index.sv
verification/tb_engine_csr_index.sv
